// ==== sim.f ====
+incdir+.
alu_types_pkg.sv
seq_types_pkg.sv
alu_shift.sv
alu_datapath.sv
shift_counter.sv
shift_sequencer.sv
alu_shift_unit.sv
tb_alu_shift_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it.
# exit status is the simulator's, nonzero on any error.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_alu_shift_unit -o sim_tb_alu_shift_unit
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_alu_shift_unit
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished with status 0"
exit 0

// ==== tb_alu_shift_unit.sv ====
`timescale 1ns/1ps
`include "cga_params.svh"

module tb_alu_shift_unit
  import alu_types_pkg::*;
  import seq_types_pkg::*;
;

  logic        clk;
  logic        reset;
  logic        start;
  alu_cmd_t    cmd;
  count_t      shift_count;
  logic        busy;
  logic        done;
  alu_result_t res;

  // galois lfsr state is advanced one bit at a time.
  logic [31:0] lfsr_q = 32'hca08_5864;

  alu_shift_unit i_alu_shift_unit (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .cmd         (cmd),
    .shift_count (shift_count),
    .busy        (busy),
    .done        (done),
    .res         (res)
  );

  // 40 ns clock.
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random source.
  ////////////////////////////////////////////////////////////
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic alu_cmd_t random_cmd();
    alu_cmd_t   c;
    logic [2:0] op_bits;
    logic [1:0] sel;
    op_bits = 3'(rand_bits(3));
    while (op_bits > 3'd5) op_bits = 3'(rand_bits(3));
    c.op = alu_op_t'(op_bits);
    c.a = word_t'(rand_bits(`ALU_WIDTH));
    c.b = word_t'(rand_bits(`ALU_WIDTH));
    // about one in eight has equal operands, so sub and xor reach zero.
    if (rand_bits(3) == 32'd0) c.b = c.a;
    sel = 2'(rand_bits(2));
    while (sel == 2'b11) sel = 2'(rand_bits(2));
    c.dir = shift_dir_t'(sel);
    sel = 2'(rand_bits(2));
    while (sel == 2'b11) sel = 2'(rand_bits(2));
    c.fill = fill_mode_t'(sel);
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model.
  ////////////////////////////////////////////////////////////
  function automatic alu_result_t model_result(input alu_cmd_t c, input count_t n);
    alu_result_t         r;
    logic [`ALU_WIDTH:0] wide;
    word_t               w;
    logic                carry;
    logic                link;
    logic                in_bit;
    w = c.a;
    carry = 1'b0;
    link = 1'b0;
    case (c.op)
      op_add: begin
        wide = (`ALU_WIDTH+1)'(c.a) + (`ALU_WIDTH+1)'(c.b);
        w = wide[`ALU_WIDTH-1:0];
        carry = wide[`ALU_WIDTH];
      end
      op_sub: begin
        // carry means no borrow.
        w = c.a - c.b;
        carry = (c.a >= c.b);
      end
      op_and: w = c.a & c.b;
      op_or:  w = c.a | c.b;
      op_xor: w = c.a ^ c.b;
      default: w = c.a;
    endcase
    for (int i = 0; i < int'(n); i++) begin
      if (c.dir == dir_left) begin
        in_bit = (c.fill == fill_rotate) ? w[`ALU_WIDTH-1] : 1'b0;
        link = w[`ALU_WIDTH-1];
        w = {w[`ALU_WIDTH-2:0], in_bit};
      end else if (c.dir == dir_right) begin
        in_bit = (c.fill == fill_rotate) ? w[0] :
                 (c.fill == fill_arith) ? w[`ALU_WIDTH-1] : 1'b0;
        link = w[0];
        w = {in_bit, w[`ALU_WIDTH-1:1]};
      end
    end
    r.word = w;
    r.carry = carry;
    r.link = link;
    r.zero = (w == '0);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks.
  ////////////////////////////////////////////////////////////
  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_result(input alu_result_t exp);
    check_value("res.word", 32'(res.word), 32'(exp.word));
    check_value("res.carry", 32'(res.carry), 32'(exp.carry));
    check_value("res.link", 32'(res.link), 32'(exp.link));
    check_value("res.zero", 32'(res.zero), 32'(exp.zero));
  endtask

  // one command from start to the end of the idle gap behind it.
  // called at a falling edge.
  task automatic run_cmd(input alu_cmd_t c, input count_t n, input logic poke);
    alu_result_t exp;
    alu_cmd_t    other;
    int          edges;
    int          gap;
    logic        seen_done;
    exp = model_result(c, n);
    other = random_cmd();
    other.a = ~c.a;
    other.op = (c.op == op_add) ? op_sub : op_add;
    start = 1'b1;
    cmd = c;
    shift_count = n;
    edges = 0;
    seen_done = 1'b0;
    while (!seen_done) begin
      @(posedge clk);
      @(negedge clk);
      edges++;
      start = 1'b0;
      // a second command while busy is to be dropped.
      if (poke && edges == 1) begin
        start = 1'b1;
        cmd = other;
        shift_count = ~n;
      end
      check_value("busy", 32'(busy), 32'd1);
      seen_done = done;
      if (!seen_done && edges > 40) begin
        $display("timeout: done did not rise within 40 cycles of start");
        stop_on_error();
      end
    end
    check_value("edges to done", 32'(edges), 32'(int'(n) + 2));
    check_result(exp);
    // done lasts one cycle and the result holds through the gap.
    gap = 1 + int'(rand_bits(3));
    repeat (gap) begin
      @(posedge clk);
      @(negedge clk);
      cmd = random_cmd();
      check_value("done", 32'(done), 32'd0);
      check_value("busy", 32'(busy), 32'd0);
      check_result(exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////////////////////////
  initial begin
    alu_cmd_t    c;
    alu_result_t zero_res;
    count_t      n;
    reset = 1'b1;
    start = 1'b0;
    cmd = '0;
    shift_count = '0;
    zero_res = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // state right after reset.
    check_value("busy", 32'(busy), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_result(zero_res);

    // every alu op with no shifting follows a one step shift that sets link.
    for (int i = 0; i < 6; i++) begin
      c = random_cmd();
      c.op = op_pass_a;
      c.a[`ALU_WIDTH-1] = 1'b1;
      c.dir = dir_left;
      run_cmd(c, count_t'(1), 1'b0);
      c = random_cmd();
      c.op = alu_op_t'(3'(i));
      run_cmd(c, count_t'(0), 1'b0);
    end

    // each direction with each fill mode at a short and the full length.
    for (int d = 0; d < 3; d++) begin
      for (int f = 0; f < 3; f++) begin
        c = random_cmd();
        c.dir = shift_dir_t'(2'(d));
        c.fill = fill_mode_t'(2'(f));
        n = count_t'(rand_bits(`CNT_WIDTH));
        if (n == '0) n = count_t'(1);
        run_cmd(c, n, 1'b0);
        run_cmd(c, count_t'(15), 1'b0);
      end
    end

    // start pulses while busy.
    for (int i = 0; i < 4; i++) begin
      run_cmd(random_cmd(), count_t'(rand_bits(`CNT_WIDTH)), 1'b1);
    end

    // mixed random commands.
    for (int i = 0; i < 40; i++) begin
      c = random_cmd();
      n = count_t'(rand_bits(`CNT_WIDTH));
      run_cmd(c, n, (rand_bits(2) == 32'd0));
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== alu_shift_unit.sv ====
`timescale 1ns/1ps

module alu_shift_unit
  import alu_types_pkg::*;
  import seq_types_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  alu_cmd_t    cmd,
  input  count_t      shift_count,
  output logic        busy,
  output logic        done,
  output alu_result_t res
);

  // sequencer strobes.
  logic       cmd_load;
  logic       alu_load;
  logic       shift_en;
  // counter flags.
  logic       count_zero;
  logic       last_step;
  // shifter loop.
  word_t      work;
  word_t      rb;
  shift_dir_t dir;
  logic       rli;
  logic       rri;

  ////////////////////////////////////////////////////////////
  // control side.
  ////////////////////////////////////////////////////////////
  shift_sequencer i_shift_sequencer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .count_zero (count_zero),
    .last_step  (last_step),
    .cmd_load   (cmd_load),
    .alu_load   (alu_load),
    .shift_en   (shift_en),
    .busy       (busy),
    .done       (done)
  );

  // count is latched with the command and stepped per shift.
  shift_counter i_shift_counter (
    .clk        (clk),
    .reset      (reset),
    .load       (cmd_load),
    .count_in   (shift_count),
    .dec        (shift_en),
    .count_zero (count_zero),
    .last_step  (last_step)
  );

  ////////////////////////////////////////////////////////////
  // data side.
  ////////////////////////////////////////////////////////////
  alu_datapath i_alu_datapath (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd),
    .cmd_load (cmd_load),
    .alu_load (alu_load),
    .shift_en (shift_en),
    .rb       (rb),
    .work     (work),
    .dir      (dir),
    .rli      (rli),
    .rri      (rri),
    .res      (res)
  );

  // working word goes through one shift step and back.
  alu_shift i_alu_shift (
    .f   (work),
    .dir (dir),
    .rli (rli),
    .rri (rri),
    .rb  (rb)
  );

endmodule

// ==== shift_sequencer.sv ====
`timescale 1ns/1ps

module shift_sequencer
  import seq_types_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic count_zero,
  input  logic last_step,
  output logic cmd_load,
  output logic alu_load,
  output logic shift_en,
  output logic busy,
  output logic done
);

  seq_state_t state_q;
  seq_state_t state_d;

  ////////////////////////////////////////////////////////////
  // state register.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // next state.
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start) begin
          state_d = st_alu;
        end
      end
      st_alu: begin
        // count of zero goes straight to done.
        if (count_zero) begin
          state_d = st_done;
        end else begin
          state_d = st_shift;
        end
      end
      st_shift: begin
        if (last_step) begin
          state_d = st_done;
        end
      end
      st_done: state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // control strobes.
  ////////////////////////////////////////////////////////////

  // start is only taken in idle, so a start while busy is dropped.
  assign cmd_load = (state_q == st_idle) && start;
  assign alu_load = (state_q == st_alu);
  assign shift_en = (state_q == st_shift);

  // status.
  assign busy     = (state_q != st_idle);
  assign done     = (state_q == st_done);

endmodule

// ==== shift_counter.sv ====
`timescale 1ns/1ps

module shift_counter
  import seq_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   load,
  input  count_t count_in,
  input  logic   dec,
  output logic   count_zero,
  output logic   last_step
);

  // remaining shift steps.
  count_t count_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= count_in;
    end else if (dec) begin
      count_q <= count_q - count_t'(1);
    end
  end

  // no shifting at all when the loaded count is zero.
  assign count_zero = (count_q == '0);

  // one step left, the shift in progress is the final one.
  assign last_step  = (count_q == count_t'(1));

endmodule

// ==== alu_datapath.sv ====
`timescale 1ns/1ps
`include "cga_params.svh"

module alu_datapath
  import alu_types_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  alu_cmd_t    cmd,
  input  logic        cmd_load,
  input  logic        alu_load,
  input  logic        shift_en,
  input  word_t       rb,
  output word_t       work,
  output shift_dir_t  dir,
  output logic        rli,
  output logic        rri,
  output alu_result_t res
);

  alu_cmd_t            cmd_q;
  word_t               work_q;
  logic                carry_q;
  logic                link_q;
  logic                zero_q;
  word_t               f;
  logic                alu_carry;
  logic [`ALU_WIDTH:0] sum;
  logic                shift_out;

  // command register, loaded on the accepting edge.
  always_ff @(posedge clk) begin
    if (cmd_load) begin
      cmd_q <= cmd;
    end
  end

  ////////////////////////////////////////////////////////////
  // alu function.
  ////////////////////////////////////////////////////////////
  always_comb begin
    sum       = '0;
    f         = cmd_q.a;
    alu_carry = 1'b0;
    case (cmd_q.op)
      op_add: begin
        sum       = {1'b0, cmd_q.a} + {1'b0, cmd_q.b};
        f         = sum[`ALU_WIDTH-1:0];
        alu_carry = sum[`ALU_WIDTH];
      end
      op_sub: begin
        // a + ~b + 1, carry out is set when no borrow.
        sum       = {1'b0, cmd_q.a} + {1'b0, ~cmd_q.b} + 1'b1;
        f         = sum[`ALU_WIDTH-1:0];
        alu_carry = sum[`ALU_WIDTH];
      end
      op_and:  f = cmd_q.a & cmd_q.b;
      op_or:   f = cmd_q.a | cmd_q.b;
      op_xor:  f = cmd_q.a ^ cmd_q.b;
      // pass a and unused codes.
      default: f = cmd_q.a;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // shift-in bits and the bit leaving the word.
  ////////////////////////////////////////////////////////////
  always_comb begin
    rli = 1'b0;
    rri = 1'b0;
    case (cmd_q.fill)
      fill_rotate: begin
        rli = work_q[`ALU_WIDTH-1];
        rri = work_q[0];
      end
      // sign bit copied in on a right shift only.
      fill_arith: rri = work_q[`ALU_WIDTH-1];
      default: ;
    endcase
  end

  always_comb begin
    case (cmd_q.dir)
      dir_left:  shift_out = work_q[`ALU_WIDTH-1];
      dir_right: shift_out = work_q[0];
      default:   shift_out = link_q;
    endcase
  end

  // working register and flags.
  always_ff @(posedge clk) begin
    if (reset) begin
      work_q  <= '0;
      carry_q <= 1'b0;
      link_q  <= 1'b0;
      zero_q  <= 1'b0;
    end else if (alu_load) begin
      work_q  <= f;
      carry_q <= alu_carry;
      link_q  <= 1'b0;
      zero_q  <= (f == '0);
    end else if (shift_en) begin
      // carry is kept across the shift steps.
      work_q  <= rb;
      link_q  <= shift_out;
      zero_q  <= (rb == '0);
    end
  end

  assign work = work_q;
  assign dir  = cmd_q.dir;
  assign res  = '{word: work_q, carry: carry_q, link: link_q, zero: zero_q};

endmodule

// ==== alu_shift.sv ====
`timescale 1ns/1ps
`include "cga_params.svh"

module alu_shift
  import alu_types_pkg::*;
(
  input  word_t      f,
  input  shift_dir_t dir,
  input  logic       rli,
  input  logic       rri,
  output word_t      rb
);

  // lower neighbour of each bit, rli enters at bit 0.
  word_t from_lo;
  // upper neighbour of each bit, rri enters at the top bit.
  word_t from_hi;

  assign from_lo = {f[`ALU_WIDTH-2:0], rli};
  assign from_hi = {rri, f[`ALU_WIDTH-1:1]};

  ////////////////////////////////////////////////////////////
  // one three input mux per bit.
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : g_bit
    always_comb begin
      case (dir)
        dir_left:  rb[i] = from_lo[i];
        dir_right: rb[i] = from_hi[i];
        // hold passes the bit straight through.
        default:   rb[i] = f[i];
      endcase
    end
  end

endmodule

// ==== seq_types_pkg.sv ====
`include "cga_params.svh"

package seq_types_pkg;

  // number of single bit shift steps still to run.
  typedef logic [`CNT_WIDTH-1:0] count_t;

  // sequencer states.
  // idle waits for start, alu loads f,
  // shift steps the word, done flags completion for one cycle.
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_alu   = 2'b01,
    st_shift = 2'b10,
    st_done  = 2'b11
  } seq_state_t;

endpackage

// ==== alu_types_pkg.sv ====
`include "cga_params.svh"

package alu_types_pkg;

  // one operand or result word.
  typedef logic [`ALU_WIDTH-1:0] word_t;

  // alu function select.
  typedef enum logic [2:0] {
    op_add    = 3'd0,
    op_sub    = 3'd1,
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    op_pass_a = 3'd5
  } alu_op_t;

  // shifter select, takes the place of the two mux select lines.
  typedef enum logic [1:0] {
    dir_hold  = 2'b00,
    dir_left  = 2'b01,
    dir_right = 2'b10
  } shift_dir_t;

  // source of the bits entering at the ends of the word.
  typedef enum logic [1:0] {
    fill_zero   = 2'b00,
    fill_rotate = 2'b01,
    fill_arith  = 2'b10
  } fill_mode_t;

  // command from the host, 39 bits.
  typedef struct packed {
    alu_op_t    op;
    word_t      a;
    word_t      b;
    shift_dir_t dir;
    fill_mode_t fill;
  } alu_cmd_t;

  // result word and flags, 19 bits.
  typedef struct packed {
    word_t word;
    logic  carry;
    logic  link;
    logic  zero;
  } alu_result_t;

endpackage

// ==== cga_params.svh ====
`ifndef CGA_PARAMS_SVH
`define CGA_PARAMS_SVH

// width of one data word in the alu slice.
`define ALU_WIDTH 16

// width of the shift count, enough for 0 to 15 steps.
`define CNT_WIDTH 4

// both widths are picked up by the two type packages
// and by the modules that slice words bit by bit.

`endif
